/* hdl/decodeStage.sv */
`timescale 1ns/1ns

module decodeStage import pipePkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    stall,
    input  logic    inValid,
    input  instrT   inInstr,
    output logic    dValid,
    output regAddrT dRs,
    output regAddrT dRt,
    input  wordT    rfRs,
    input  wordT    rfRt,
    input  fwdSelT  fwdRs,
    input  fwdSelT  fwdRt,
    input  tokenT   stageTokens [NUM_STAGES],
    output tokenT   tokenOut
);

    instrT dInstr;
    wordT  opA;
    wordT  opB;

    function automatic wordT pickOperand(fwdSelT sel, wordT rfVal, wordT eVal,
                                         wordT mVal, wordT m2Val, wordT wVal);
        case (sel)
            FWD_E:   return eVal;
            FWD_M:   return mVal;
            FWD_M2:  return m2Val;
            FWD_W:   return wVal;
            default: return rfVal;
        endcase
    endfunction

    // D register, holds while stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            dValid <= 1'b0;
        end else if (!stall) begin
            dValid <= inValid;
            dInstr <= inInstr;
        end
    end

    assign dRs = dInstr.rs;
    assign dRt = dInstr.rt;

    assign opA = pickOperand(fwdRs, rfRs, stageTokens[STAGE_E].result,
                             stageTokens[STAGE_M].result, stageTokens[STAGE_M2].result,
                             stageTokens[STAGE_W].result);
    assign opB = pickOperand(fwdRt, rfRt, stageTokens[STAGE_E].result,
                             stageTokens[STAGE_M].result, stageTokens[STAGE_M2].result,
                             stageTokens[STAGE_W].result);

    always_comb begin
        tokenOut.valid    = dValid;
        tokenOut.regWrite = dValid && (dInstr.rd != '0);
        tokenOut.memRead  = dValid && (dInstr.op == OP_LOAD);
        tokenOut.rd       = dInstr.rd;
        case (dInstr.op)
            OP_XOR:  tokenOut.result = opA ^ opB;
            OP_LOAD: tokenOut.result = opA + wordT'(dInstr.imm); // load address
            default: tokenOut.result = opA + opB;
        endcase
    end

endmodule

/* hdl/hazardUnit.sv */
`timescale 1ns/1ns

module hazardUnit import pipePkg::*; (
    input  logic                  dValid,
    input  regAddrT               dRs,
    input  regAddrT               dRt,
    input  tokenT                 stageTokens [NUM_STAGES],
    input  logic                  memBusy,
    output fwdSelT                fwdRs,
    output fwdSelT                fwdRt,
    output logic                  queueStall,
    output logic                  decodeStall,
    output logic [NUM_STAGES-1:0] stageStall,
    output logic [NUM_STAGES-1:0] stageFlush
);

    logic useFromE;
    logic useFromM;
    logic loadUse;
    logic upperStall;

    function automatic logic hits(regAddrT src, tokenT tok);
        return (src != '0) && tok.valid && tok.regWrite && (tok.rd == src);
    endfunction

    // youngest producer wins
    function automatic fwdSelT fwdFor(regAddrT src, tokenT e, tokenT m,
                                      tokenT m2, tokenT w);
        if (hits(src, e))       return FWD_E;
        else if (hits(src, m))  return FWD_M;
        else if (hits(src, m2)) return FWD_M2;
        else if (hits(src, w))  return FWD_W;
        else                    return FWD_NONE;
    endfunction

    assign fwdRs = fwdFor(dRs, stageTokens[STAGE_E], stageTokens[STAGE_M],
                          stageTokens[STAGE_M2], stageTokens[STAGE_W]);
    assign fwdRt = fwdFor(dRt, stageTokens[STAGE_E], stageTokens[STAGE_M],
                          stageTokens[STAGE_M2], stageTokens[STAGE_W]);

    // load data only exists from M2 on
    assign useFromE = ((fwdRs == FWD_E) || (fwdRt == FWD_E)) && stageTokens[STAGE_E].memRead;
    assign useFromM = ((fwdRs == FWD_M) || (fwdRt == FWD_M)) && stageTokens[STAGE_M].memRead;
    assign loadUse  = dValid && (useFromE || useFromM);

    assign upperStall  = memBusy | loadUse;
    assign queueStall  = upperStall;
    assign decodeStall = upperStall;

    always_comb begin
        stageStall = '0;
        stageFlush = '0;
        stageStall[STAGE_E]  = memBusy;              // hold behind the waiting load
        stageStall[STAGE_M]  = memBusy;
        stageFlush[STAGE_E]  = loadUse & ~memBusy;   // bubble for load-use
        stageFlush[STAGE_M2] = memBusy;              // nothing leaves M yet
    end

endmodule

/* hdl/instrQueue.sv */
`timescale 1ns/1ns

module instrQueue import pipePkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  instValid,
    input  instrT instr,
    input  logic  stall,
    output logic  credit,
    output logic  headValid,
    output instrT head
);

    instrT             mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0] wrPtr;
    logic [QPTR_W-1:0] rdPtr;
    logic [QPTR_W:0]   count;
    logic              pop;

    assign headValid = (count != '0);
    assign head      = mem[rdPtr];
    assign pop       = headValid & ~stall; // head moves into D

    // credit flow keeps a free slot for every write
    always_ff @(posedge clk) begin
        if (instValid) begin
            mem[wrPtr] <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr  <= '0;
            rdPtr  <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (instValid) wrPtr <= wrPtr + 1'b1; // pointers wrap at depth
            if (pop) rdPtr <= rdPtr + 1'b1;
            case ({instValid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit <= pop; // one credit back per pop
        end
    end

endmodule

/* hdl/memAccess.sv */
`timescale 1ns/1ns

module memAccess import pipePkg::*; (
    input  tokenT mToken,
    input  logic  memAck,
    input  wordT  memRdata,
    output logic  memReq,
    output wordT  memAddr,
    output logic  memBusy,
    output tokenT m2TokenIn
);

    logic isLoad;

    assign isLoad  = mToken.valid & mToken.memRead;
    assign memReq  = isLoad;           // held until memAck
    assign memAddr = mToken.result;
    assign memBusy = isLoad & ~memAck;

    always_comb begin
        m2TokenIn = mToken;
        if (isLoad) begin
            m2TokenIn.result = memRdata; // data taken with the ack
        end
    end

endmodule

/* hdl/pipePkg.sv */
package pipePkg;

    typedef logic [31:0] wordT;    // data word
    typedef logic [4:0]  regAddrT; // register number, r0 reads zero

    typedef enum logic [1:0] {
        OP_ADD  = 2'd0,
        OP_XOR  = 2'd1,
        OP_LOAD = 2'd2
    } opT;

    typedef struct packed {
        opT          op;
        regAddrT     rs;
        regAddrT     rt;
        regAddrT     rd;
        logic [7:0]  imm;  // zero-extended load offset
    } instrT;

    // one pipeline slot after decode
    typedef struct packed {
        logic    valid;
        logic    regWrite;
        logic    memRead;
        regAddrT rd;
        wordT    result;   // alu value, load address, then load data from M2 on
    } tokenT;

    // forwarding source for a decode operand
    typedef enum logic [2:0] {
        FWD_NONE = 3'b000,
        FWD_W    = 3'b001,
        FWD_M2   = 3'b010,
        FWD_M    = 3'b011,
        FWD_E    = 3'b100
    } fwdSelT;

    localparam int QUEUE_DEPTH = 4;   // queue size and initial credits
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int NUM_STAGES  = 4;   // stages after decode
    localparam int NUM_REGS    = 32;

    localparam int STAGE_E  = 0;
    localparam int STAGE_M  = 1;
    localparam int STAGE_M2 = 2;
    localparam int STAGE_W  = 3;

endpackage

/* hdl/pipeStage.sv */
`timescale 1ns/1ns

module pipeStage import pipePkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  stall,
    input  logic  flush,
    input  tokenT tokenIn,
    output tokenT tokenOut
);

    // a bubble clears the control bits only
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tokenOut.valid    <= 1'b0;
            tokenOut.regWrite <= 1'b0;
            tokenOut.memRead  <= 1'b0;
        end else if (!stall) begin
            tokenOut <= tokenIn;
        end
    end

endmodule

/* hdl/pipeTop.sv */
`timescale 1ns/1ns

module pipeTop import pipePkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    instValid,
    input  instrT   instr,
    output logic    credit,
    output logic    memReq,
    output wordT    memAddr,
    input  logic    memAck,
    input  wordT    memRdata,
    output logic    retireValid,
    output regAddrT retireRd,
    output wordT    retireData
);

    logic                  headValid;
    instrT                 head;
    logic                  queueStall;
    logic                  decodeStall;
    logic                  dValid;
    regAddrT               dRs;
    regAddrT               dRt;
    wordT                  rfRs;
    wordT                  rfRt;
    fwdSelT                fwdRs;
    fwdSelT                fwdRt;
    tokenT                 decodeToken;
    tokenT                 m2TokenIn;
    logic                  memBusy;
    logic [NUM_STAGES-1:0] stageStall;
    logic [NUM_STAGES-1:0] stageFlush;
    tokenT                 stageIn  [NUM_STAGES];
    tokenT                 stageOut [NUM_STAGES];

    instrQueue uQueue (
        .clk(clk), .rst(rst), .instValid(instValid), .instr(instr),
        .stall(queueStall), .credit(credit), .headValid(headValid), .head(head)
    );

    decodeStage uDecode (
        .clk(clk), .rst(rst), .stall(decodeStall), .inValid(headValid), .inInstr(head),
        .dValid(dValid), .dRs(dRs), .dRt(dRt), .rfRs(rfRs), .rfRt(rfRt),
        .fwdRs(fwdRs), .fwdRt(fwdRt), .stageTokens(stageOut), .tokenOut(decodeToken)
    );

    hazardUnit uHazard (
        .dValid(dValid), .dRs(dRs), .dRt(dRt), .stageTokens(stageOut), .memBusy(memBusy),
        .fwdRs(fwdRs), .fwdRt(fwdRt), .queueStall(queueStall), .decodeStall(decodeStall),
        .stageStall(stageStall), .stageFlush(stageFlush)
    );

    // E <- decode, M <- E, M2 <- memory merge, W <- M2
    assign stageIn[STAGE_E]  = decodeToken;
    assign stageIn[STAGE_M]  = stageOut[STAGE_E];
    assign stageIn[STAGE_M2] = m2TokenIn;
    assign stageIn[STAGE_W]  = stageOut[STAGE_M2];

    for (genvar g = 0; g < NUM_STAGES; g++) begin : gStage
        pipeStage uStage (
            .clk(clk), .rst(rst), .stall(stageStall[g]), .flush(stageFlush[g]),
            .tokenIn(stageIn[g]), .tokenOut(stageOut[g])
        );
    end

    memAccess uMem (
        .mToken(stageOut[STAGE_M]), .memAck(memAck), .memRdata(memRdata),
        .memReq(memReq), .memAddr(memAddr), .memBusy(memBusy), .m2TokenIn(m2TokenIn)
    );

    regWriteback uWb (
        .clk(clk), .rst(rst), .wToken(stageOut[STAGE_W]), .rdRs(dRs), .rdRt(dRt),
        .rfRs(rfRs), .rfRt(rfRt), .retireValid(retireValid), .retireRd(retireRd),
        .retireData(retireData)
    );

endmodule

/* hdl/regWriteback.sv */
`timescale 1ns/1ns

module regWriteback import pipePkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  tokenT   wToken,
    input  regAddrT rdRs,
    input  regAddrT rdRt,
    output wordT    rfRs,
    output wordT    rfRt,
    output logic    retireValid,
    output regAddrT retireRd,
    output wordT    retireData
);

    wordT regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wToken.valid && wToken.regWrite && (wToken.rd != '0)) begin
            regs[wToken.rd] <= wToken.result; // r0 never written
        end
    end

    // same-cycle W writes reach decode through forwarding
    assign rfRs = regs[rdRs];
    assign rfRt = regs[rdRt];

    assign retireValid = wToken.valid;
    assign retireRd    = wToken.rd;
    assign retireData  = wToken.result; // also shown for rd = 0

endmodule

/* run.sh */
#!/bin/sh
# build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pipeTb -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/VpipeTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

/* verif/pipeTb.sv */
`timescale 1ns/1ns

module pipeTb import pipePkg::*; ();

    localparam int TOTAL_INSTR    = 8 + 8 + 24 + 12 + 5 + 150; // preload plus tests 2 to 6
    localparam int TIMEOUT_CYCLES = TOTAL_INSTR * 12 + 200;

    logic    clk = 1'b0;
    logic    rst;
    logic    instValid;
    instrT   instr;
    logic    credit;
    logic    memReq;
    wordT    memAddr;
    logic    memAck = 1'b0;
    wordT    memRdata = '0;
    logic    retireValid;
    regAddrT retireRd;
    wordT    retireData;

    int      seed = 67928;
    int      memSeed = 67928;  // separate stream for memory latency
    int      memWait = 0;
    int      credits = QUEUE_DEPTH;
    int      cycles = 0;
    int      errors = 0;
    int      sent = 0;
    int      retired = 0;
    wordT    refRegs [NUM_REGS] = '{default: '0};
    regAddrT expRd [$];
    wordT    expData [$];

    pipeTop uut (
        .clk(clk), .rst(rst), .instValid(instValid), .instr(instr), .credit(credit),
        .memReq(memReq), .memAddr(memAddr), .memAck(memAck), .memRdata(memRdata),
        .retireValid(retireValid), .retireRd(retireRd), .retireData(retireData)
    );

    always #4 clk = ~clk;

    // memory model, acks each request after a random wait
    always @(posedge clk) begin
        if (rst) begin
            memAck  <= 1'b0;
            memWait <= 0;
        end else if (memAck) begin
            memAck <= 1'b0;   // load leaves M on this edge
        end else if (memReq) begin
            if (memWait == 0) begin
                memWait <= 1 + int'($unsigned($random(memSeed)) % 3);
            end else if (memWait == 1) begin
                memAck   <= 1'b1;
                memRdata <= memAddr * 32'h9E3779B1;
                memWait  <= 0;
            end else begin
                memWait <= memWait - 1;
            end
        end
    end

    // source credit counter
    always @(posedge clk) begin
        if (rst) begin
            credits <= QUEUE_DEPTH;
        end else begin
            credits <= credits + int'(credit) - int'(instValid);
            assert (credits >= 0 && credits <= QUEUE_DEPTH) else begin
                $display("credit count out of range: %0d", credits);
                errors++;
            end
        end
    end

    // every retire against the reference queue
    always @(posedge clk) begin
        if (!rst && retireValid) begin
            retired++;
            assert (expRd.size() != 0) else begin
                $display("retire seen with no instruction outstanding");
                errors++;
            end
            if (expRd.size() != 0) begin
                assert (retireRd == expRd[0]) else begin
                    $display("FAILED retireRd: got %h, expected %h", retireRd, expRd[0]);
                    errors++;
                end
                assert (retireData == expData[0]) else begin
                    $display("FAILED retireData: got %h, expected %h", retireData, expData[0]);
                    errors++;
                end
                expRd.pop_front();
                expData.pop_front();
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d retired", cycles, retired, sent);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic instrT mkInstr(opT op, int rs, int rt, int rd, int imm);
        instrT ins;
        ins.op  = op;
        ins.rs  = regAddrT'(rs);
        ins.rt  = regAddrT'(rt);
        ins.rd  = regAddrT'(rd);
        ins.imm = 8'(imm);
        return ins;
    endfunction

    function automatic int randReg();
        return int'($unsigned($random(seed)) % 32);
    endfunction

    // in-order reference, r0 stays zero
    task automatic refExec(input instrT ins);
        wordT a;
        wordT b;
        wordT v;
        a = refRegs[ins.rs];
        b = refRegs[ins.rt];
        case (ins.op)
            OP_XOR:  v = a ^ b;
            OP_LOAD: v = (a + {24'd0, ins.imm}) * 32'h9E3779B1;
            default: v = a + b;
        endcase
        if (ins.rd != 5'd0) refRegs[ins.rd] = v;
        expRd.push_back(ins.rd);
        expData.push_back(v);
        sent++;
    endtask

    task automatic sendInstr(input instrT ins);
        @(posedge clk);
        while (credits + int'(credit) - int'(instValid) <= 0) begin // credits left after this edge
            instValid <= 1'b0;
            @(posedge clk);
        end
        instValid <= 1'b1;
        instr     <= ins;
        refExec(ins);
    endtask

    task automatic drain();
        @(posedge clk);
        instValid <= 1'b0;
        while (expRd.size() != 0) @(posedge clk);
    endtask

    task automatic reportTest(input string name, input int errBefore);
        $display("%-22s %s (%0d errors)", name, (errors == errBefore) ? "ok" : "failed",
                 errors - errBefore);
    endtask

    initial begin
        int errBefore;
        int x;
        rst       = 1'b1;
        instValid = 1'b0;
        instr     = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        errBefore = errors;
        repeat (10) begin
            @(posedge clk);
            assert (!credit && !memReq && !retireValid) else begin
                $display("outputs active with no instruction sent");
                errors++;
            end
        end
        reportTest("idle after reset", errBefore);

        errBefore = errors;
        for (int k = 1; k <= 8; k++) sendInstr(mkInstr(OP_LOAD, 0, 0, k, 16 + k)); // seed r1..r8
        drain();
        for (int k = 0; k < 8; k++) begin
            sendInstr(mkInstr((k % 2 != 0) ? OP_XOR : OP_ADD, 1 + k % 4, 5 + k % 4, 16 + k, 0));
        end
        drain();
        reportTest("independent alu", errBefore);

        errBefore = errors;
        for (int d = 1; d <= 4; d++) begin
            for (int j = 0; j < 6; j++) begin
                x = (j >= d) ? 10 + j - d : 1;  // reads the rd written d back
                sendInstr(mkInstr((j % 2 != 0) ? OP_XOR : OP_ADD, x, 2 + j % 4, 10 + j, 0));
            end
            drain();
        end
        reportTest("forwarding chains", errBefore);

        errBefore = errors;
        for (int d = 1; d <= 3; d++) begin
            sendInstr(mkInstr(OP_LOAD, 1 + d, 0, 24, 4 * d));
            for (int f = 1; f < d; f++) sendInstr(mkInstr(OP_ADD, 1, 2, 25, 0));
            sendInstr(mkInstr(OP_ADD, 24, 3, 26, 0));
            sendInstr(mkInstr(OP_XOR, 5, 24, 27, 0));
            drain();
        end
        reportTest("load use", errBefore);

        errBefore = errors;
        sendInstr(mkInstr(OP_ADD, 1, 2, 0, 0));
        sendInstr(mkInstr(OP_XOR, 3, 4, 0, 0));
        sendInstr(mkInstr(OP_LOAD, 1, 0, 0, 1));
        sendInstr(mkInstr(OP_ADD, 0, 0, 28, 0));
        sendInstr(mkInstr(OP_XOR, 0, 5, 29, 0));
        drain();
        reportTest("register zero", errBefore);

        errBefore = errors;
        for (int k = 0; k < 150; k++) begin
            x = int'($unsigned($random(seed)) % 3);
            sendInstr(mkInstr((x == 0) ? OP_ADD : (x == 1) ? OP_XOR : OP_LOAD,
                              randReg(), randReg(), randReg(), randReg() * 8));
        end
        drain();
        assert (credits == QUEUE_DEPTH) else begin
            $display("credits did not return to queue depth, %0d held", credits);
            errors++;
        end
        assert (retired == sent) else begin
            $display("retire count %0d does not match %0d sent", retired, sent);
            errors++;
        end
        reportTest("random mix", errBefore);

        $display("summary: %0d errors, %0d sent, %0d retired", errors, sent, retired);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
hdl/pipePkg.sv
hdl/instrQueue.sv
hdl/decodeStage.sv
hdl/hazardUnit.sv
hdl/pipeStage.sv
hdl/memAccess.sv
hdl/regWriteback.sv
hdl/pipeTop.sv
verif/pipeTb.sv
